// File: logic/ecc_params.svh
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// ####################
// Code geometry
// ####################

// Number of protected data bits.
`define ECC_DATA_WIDTH 111

// Seven Hamming bits plus one overall parity bit.
`define ECC_PARITY_WIDTH 8

// Width of a Hamming position. 2**7 covers positions up to 127.
`define ECC_POS_WIDTH 7

// Lowest position that is not a power of two.
`define ECC_FIRST_POS 3

`endif

// File: logic/ecc_pkg.sv
`default_nettype none

`include "ecc_params.svh"

package ecc_pkg;

    // ####################
    // Types
    // ####################

    typedef logic [`ECC_DATA_WIDTH-1:0] ecc_data_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_parity_t; // Check word or syndrome.

    typedef enum logic [1:0] {
        ecc_clean,
        ecc_data_fixed,
        ecc_parity_fixed,
        ecc_uncorrectable
    } ecc_status_e;

    typedef enum logic [1:0] {
        link_idle,
        link_eval,
        link_ack
    } link_state_e;

    // ####################
    // Column rule
    // ####################

    // Data bit idx sits at the idx-th position that is not a power of two,
    // counting from ECC_FIRST_POS. The top bit makes every column odd weight.
    function automatic ecc_parity_t data_column(input int unsigned idx);
        logic [`ECC_POS_WIDTH-1:0] pos;
        int unsigned count;
        int unsigned p;
        pos = '0;
        count = 0;
        for (p = `ECC_FIRST_POS; p < (1 << `ECC_POS_WIDTH); p++) begin
            if ((p & (p - 1)) != 0) begin
                if (count == idx) begin
                    pos = `ECC_POS_WIDTH'(p);
                end
                count++;
            end
        end
        return {~^pos, pos}; // Set when pos has an even number of ones.
    endfunction

endpackage

`default_nettype wire

// File: logic/ecc_encoder.sv
`default_nettype none

`include "ecc_params.svh"

module ecc_encoder
    import ecc_pkg::*;
(
    input  ecc_data_t   data,
    output ecc_parity_t parity
);

    // ####################
    // Parity generation
    // ####################

    // Check bit i collects every data bit whose column has bit i set.
    // Summing the columns of all set data bits gives the same result.
    always_comb begin : encode
        int k;
        parity = '0;
        for (k = 0; k < `ECC_DATA_WIDTH; k++) begin
            if (data[k]) begin
                parity = parity ^ data_column(k); // Columns are constants after unrolling.
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/ecc_syndrome_decoder.sv
`default_nettype none

`include "ecc_params.svh"

module ecc_syndrome_decoder
    import ecc_pkg::*;
(
    input  ecc_data_t   data,
    input  ecc_parity_t parity_in,
    input  ecc_parity_t calc_parity,
    output ecc_data_t   mask,
    output ecc_status_e status
);

    ecc_parity_t syndrome;
    logic        syn_zero;
    logic        syn_one_hot;
    logic        col_hit;

    assign syndrome = parity_in ^ calc_parity;

    // ####################
    // Column match
    // ####################

    // Columns are distinct, so at most one mask bit can be set.
    genvar k;
    generate
        for (k = 0; k < `ECC_DATA_WIDTH; k++) begin : g_col
            assign mask[k] = (syndrome == data_column(k));
        end
    endgenerate

    assign col_hit = |mask;

    // ####################
    // Classification
    // ####################

    assign syn_zero    = (syndrome == '0);
    assign syn_one_hot = !syn_zero && ((syndrome & (syndrome - 1'b1)) == '0);

    // A data column has odd weight of at least three, so a one-hot
    // syndrome always points at a check bit.
    always_comb begin
        if (syn_zero) begin
            status = ecc_clean;
        end else if (col_hit) begin
            status = ecc_data_fixed;
        end else if (syn_one_hot) begin
            status = ecc_parity_fixed;
        end else begin
            status = ecc_uncorrectable; // Even weight or an unused odd column.
        end
    end

endmodule

`default_nettype wire

// File: logic/ecc_check_link.sv
`default_nettype none

`include "ecc_params.svh"

module ecc_check_link
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    output logic        ack,
    input  ecc_data_t   data_in,
    input  ecc_parity_t parity_in,
    input  logic        bypass,
    output ecc_data_t   cap_data,
    output ecc_parity_t cap_parity,
    input  ecc_parity_t calc_parity,
    input  ecc_data_t   mask,
    input  ecc_status_e status,
    output ecc_data_t   data_out,
    output ecc_parity_t parity_out,
    output logic        sbit_err,
    output logic        dbit_err
);

    link_state_e state;
    logic        cap_bypass;
    logic        single_err;
    logic        double_err;

    // ####################
    // Handshake FSM
    // ####################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= link_idle;
            ack      <= 1'b0;
            sbit_err <= 1'b0;
            dbit_err <= 1'b0;
        end else begin
            case (state)
                link_idle: begin
                    if (req) begin
                        state <= link_eval; // Word is captured on this edge.
                    end
                end
                link_eval: begin
                    state    <= link_ack;
                    ack      <= 1'b1;
                    sbit_err <= single_err;
                    dbit_err <= double_err;
                end
                link_ack: begin
                    // Hold everything until the host lets go of req.
                    if (!req) begin
                        state <= link_idle;
                        ack   <= 1'b0;
                    end
                end
                default: begin
                    state <= link_idle;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // ####################
    // Capture and results
    // ####################

    always_ff @(posedge clk) begin
        if (state == link_idle && req) begin
            cap_data   <= data_in;
            cap_parity <= parity_in;
            cap_bypass <= bypass;
        end
    end

    assign single_err = !cap_bypass &&
                        (status == ecc_data_fixed || status == ecc_parity_fixed);
    assign double_err = !cap_bypass && (status == ecc_uncorrectable);

    always_ff @(posedge clk) begin
        if (state == link_eval) begin
            data_out   <= cap_bypass ? cap_data : (cap_data ^ mask);
            parity_out <= calc_parity; // Always the clean encoding of the data.
        end
    end

endmodule

`default_nettype wire

// File: logic/ecc_111_top.sv
`default_nettype none

`include "ecc_params.svh"

module ecc_111_top
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    output logic        ack,
    input  ecc_data_t   data_in,
    input  ecc_parity_t parity_in,
    input  logic        bypass,
    output ecc_data_t   data_out,
    output ecc_parity_t parity_out,
    output logic        sbit_err,
    output logic        dbit_err
);

    ecc_data_t   cap_data;
    ecc_parity_t cap_parity;
    ecc_parity_t calc_parity;
    ecc_data_t   mask;
    ecc_status_e status;

    // ####################
    // Handshake and storage
    // ####################

    ecc_check_link u_link (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .ack         (ack),
        .data_in     (data_in),
        .parity_in   (parity_in),
        .bypass      (bypass),
        .cap_data    (cap_data),
        .cap_parity  (cap_parity),
        .calc_parity (calc_parity),
        .mask        (mask),
        .status      (status),
        .data_out    (data_out),
        .parity_out  (parity_out),
        .sbit_err    (sbit_err),
        .dbit_err    (dbit_err)
    );

    // ####################
    // Code logic
    // ####################

    // Encoder and decoder sit between the capture and result registers.
    ecc_encoder u_encoder (
        .data   (cap_data),
        .parity (calc_parity)
    );

    ecc_syndrome_decoder u_decoder (
        .data        (cap_data),
        .parity_in   (cap_parity),
        .calc_parity (calc_parity),
        .mask        (mask),
        .status      (status)
    );

endmodule

`default_nettype wire

// File: verif/ecc_tb.sv
`default_nettype none

`include "ecc_params.svh"

module ecc_tb
    import ecc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period      = 100;
    localparam int drive_delay     = 5;
    localparam int reset_cycles    = 10;
    localparam int ack_limit       = 8;   // Edges to wait for ack before giving up.
    localparam int cycles_per_test = 40;
    localparam int slack_cycles    = 100;
    localparam logic [31:0] lfsr_seed = 32'd68630;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;
    localparam string tests_path = "verif/ecc_tests.txt";

    logic        clk;
    logic        rst_n;
    logic        req;
    logic        ack;
    ecc_data_t   data_in;
    ecc_parity_t parity_in;
    logic        bypass;
    ecc_data_t   data_out;
    ecc_parity_t parity_out;
    logic        sbit_err;
    logic        dbit_err;

    // One entry per line of the tests file.
    string       test_name[$];
    ecc_data_t   test_data_in[$];
    ecc_parity_t test_parity_in[$];
    logic        test_bypass[$];
    ecc_data_t   exp_data_out[$];
    ecc_parity_t exp_parity_out[$];
    logic        exp_sbit[$];
    logic        exp_dbit[$];

    int          error_count;
    int          pass_count;
    int          fail_count;
    logic        tests_loaded;
    logic [31:0] lfsr_state;

    ecc_111_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .ack        (ack),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // ####################
    // Helpers
    // ####################

    // Right-shifting Galois LFSR, 32 bits.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ lfsr_taps;
        end
        return next;
    endfunction

    task automatic draw_bits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // One step per bit taken.
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    // Inputs change and outputs are sampled a little after the rising edge.
    task automatic step_cycle();
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic load_tests();
        int          fd;
        int          fields;
        int          line_no;
        string       line;
        string       name;
        ecc_data_t   d_in;
        ecc_data_t   d_out;
        ecc_parity_t p_in;
        ecc_parity_t p_out;
        logic        byp;
        logic        sb;
        logic        db;
        fd = $fopen(tests_path, "r");
        if (fd == 0) begin
            $display("Error: cannot open the tests file %s", tests_path);
            error_count++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() < 2 || line[0] == "#") begin
                continue; // Blank line or column legend.
            end
            fields = $sscanf(line, "%s %h %h %b %h %h %b %b",
                             name, d_in, p_in, byp, d_out, p_out, sb, db);
            if (fields != 8) begin
                $display("Error: line %0d of %s cannot be parsed", line_no, tests_path);
                error_count++;
            end else begin
                test_name.push_back(name);
                test_data_in.push_back(d_in);
                test_parity_in.push_back(p_in);
                test_bypass.push_back(byp);
                exp_data_out.push_back(d_out);
                exp_parity_out.push_back(p_out);
                exp_sbit.push_back(sb);
                exp_dbit.push_back(db);
            end
        end
        $fclose(fd);
    endtask

    // ####################
    // One handshake
    // ####################

    task automatic run_test(input int idx);
        int          gap;
        int          hold;
        int          edges;
        int          fails;
        logic        stable;
        ecc_data_t   held_data;
        ecc_parity_t held_parity;
        logic        held_sbit;
        logic        held_dbit;
        fails = 0;
        draw_bits(3, gap);
        draw_bits(3, hold);
        repeat (gap) step_cycle();

        if (ack !== 1'b0) begin
            $display("Error at %0d ns: ack is high before req in %s", $time, test_name[idx]);
            fails++;
        end
        data_in   = test_data_in[idx];
        parity_in = test_parity_in[idx];
        bypass    = test_bypass[idx];
        req       = 1'b1;

        edges = 0;
        do begin
            step_cycle();
            edges++;
        end while (ack !== 1'b1 && edges < ack_limit);

        if (ack !== 1'b1) begin
            $display("Error at %0d ns: ack never rose within %0d cycles in %s",
                     $time, ack_limit, test_name[idx]);
            fails++;
        end else begin
            if (edges != 2) begin
                $display("Error at %0d ns: ack rose %0d cycles after req instead of 2 in %s",
                         $time, edges, test_name[idx]);
                fails++;
            end
            if (data_out !== exp_data_out[idx]) begin
                $display("Mismatch at %0d ns: %s data_out is %h, expected %h",
                         $time, test_name[idx], data_out, exp_data_out[idx]);
                fails++;
            end
            if (parity_out !== exp_parity_out[idx]) begin
                $display("Mismatch at %0d ns: %s parity_out is %h, expected %h",
                         $time, test_name[idx], parity_out, exp_parity_out[idx]);
                fails++;
            end
            if (sbit_err !== exp_sbit[idx]) begin
                $display("Mismatch at %0d ns: %s sbit_err is %b, expected %b",
                         $time, test_name[idx], sbit_err, exp_sbit[idx]);
                fails++;
            end
            if (dbit_err !== exp_dbit[idx]) begin
                $display("Mismatch at %0d ns: %s dbit_err is %b, expected %b",
                         $time, test_name[idx], dbit_err, exp_dbit[idx]);
                fails++;
            end

            // Host keeps req high for a random while; nothing may move.
            held_data   = data_out;
            held_parity = parity_out;
            held_sbit   = sbit_err;
            held_dbit   = dbit_err;
            stable      = 1'b1;
            repeat (hold) begin
                step_cycle();
                if (stable && (ack !== 1'b1 || data_out !== held_data ||
                               parity_out !== held_parity || sbit_err !== held_sbit ||
                               dbit_err !== held_dbit)) begin
                    $display("Error at %0d ns: ack or an output changed while req was held in %s",
                             $time, test_name[idx]);
                    stable = 1'b0;
                    fails++;
                end
            end
        end

        req = 1'b0;
        step_cycle();
        if (ack !== 1'b0) begin
            $display("Error at %0d ns: ack did not fall one cycle after req fell in %s",
                     $time, test_name[idx]);
            fails++;
        end

        error_count += fails;
        if (fails == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("%0d ns  %-18s %s", $time, test_name[idx], (fails == 0) ? "pass" : "fail");
    endtask

    // ####################
    // Main sequence
    // ####################

    initial begin : main
        int i;
        rst_n        = 1'b0;
        req          = 1'b0;
        data_in      = '0;
        parity_in    = '0;
        bypass       = 1'b0;
        error_count  = 0;
        pass_count   = 0;
        fail_count   = 0;
        tests_loaded = 1'b0;
        lfsr_state   = lfsr_seed;

        load_tests();
        tests_loaded = 1'b1;
        if (test_name.size() == 0) begin
            $display("Error: no tests were read from %s", tests_path);
            error_count++;
        end

        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        rst_n = 1'b1;
        if (ack !== 1'b0 || sbit_err !== 1'b0 || dbit_err !== 1'b0) begin
            $display("Error at %0d ns: ack or an error flag is not low after reset", $time);
            error_count++;
        end

        for (i = 0; i < test_name.size(); i++) begin
            run_test(i);
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 test_name.size(), pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // The limit follows the number of tests in the file.
    initial begin : watchdog
        int limit;
        wait (tests_loaded === 1'b1);
        limit = test_name.size() * cycles_per_test + slack_cycles;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/ecc_pkg.sv
logic/ecc_encoder.sv
logic/ecc_syndrome_decoder.sv
logic/ecc_check_link.sv
logic/ecc_111_top.sv
verif/ecc_tb.sv

// File: verif/ecc_tests.txt
# name data_in parity_in bypass exp_data_out exp_parity_out exp_sbit_err exp_dbit_err
# Data and parity columns are hex; bypass and the two flags are single bits.
clean_zero       0000000000000000000000000000 00 0 0000000000000000000000000000 00 0 0
clean_bit0       0000000000000000000000000001 83 0 0000000000000000000000000001 83 0 0
clean_mix        4000000000000080000000000001 cb 0 4000000000000080000000000001 cb 0 0
clean_low16      000000000000000000000000ffff 1e 0 000000000000000000000000ffff 1e 0 0
data_flip_lo     4000000000000080000000000000 cb 0 4000000000000080000000000001 48 1 0
data_flip_mid    4000000000000000000000000001 cb 0 4000000000000080000000000001 f5 1 0
data_flip_hi     0000000000000080000000000001 cb 0 4000000000000080000000000001 bd 1 0
data_flip_low16  000000000000000000000000fffe 1e 0 000000000000000000000000ffff 9d 1 0
data_flip_zero   4000000000000000000000000000 00 0 0000000000000000000000000000 76 1 0
chk_flip_0       4000000000000080000000000001 ca 0 4000000000000080000000000001 cb 1 0
chk_flip_1       4000000000000080000000000001 c9 0 4000000000000080000000000001 cb 1 0
chk_flip_2       4000000000000080000000000001 cf 0 4000000000000080000000000001 cb 1 0
chk_flip_3       4000000000000080000000000001 c3 0 4000000000000080000000000001 cb 1 0
chk_flip_4       4000000000000080000000000001 db 0 4000000000000080000000000001 cb 1 0
chk_flip_5       4000000000000080000000000001 eb 0 4000000000000080000000000001 cb 1 0
chk_flip_6       4000000000000080000000000001 8b 0 4000000000000080000000000001 cb 1 0
chk_flip_7       4000000000000080000000000001 4b 0 4000000000000080000000000001 cb 1 0
double_data      4000000000000000000000000000 cb 0 4000000000000000000000000000 76 0 1
double_data_zero 4000000000000000000000000001 00 0 4000000000000000000000000001 f5 0 1
double_data_chk  000000000000000000000000fffe 1f 0 000000000000000000000000fffe 9d 0 1
double_chk       0000000000000000000000000001 80 0 0000000000000000000000000001 83 0 1
bypass_data_flip 4000000000000080000000000000 cb 1 4000000000000080000000000000 48 0 0
bypass_double    4000000000000000000000000000 cb 1 4000000000000000000000000000 76 0 0
bypass_chk_flip  4000000000000080000000000001 4b 1 4000000000000080000000000001 cb 0 0
